/* all.f */
btac_pkg.sv
btb.sv
btac_lookup.sv
btac_resolve.sv
btac.sv
btac_props.sv
btac_checker.sv
tb_btac.sv

/* tb_btac.sv */
`timescale 1ns/1ps

module tb_btac import btac_pkg::*; ();

  localparam int n_empty = 30;
  localparam int n_write = 24;
  localparam int n_merge = 60;
  localparam int n_taken = 20;
  localparam int n_clear = 60;
  // Worst case cycles of all tests plus reset, phase starts and wind-down
  localparam int total_cycles = 3 + n_empty + 3 * n_write + n_merge + 4 * n_taken
                                + n_clear + 12;
  localparam int watchdog_ns = total_cycles * 20 + 1000;

  logic            clock;
  logic            reset;
  logic            clear;
  logic [xlen-1:0] get_pc;
  logic            upd_jal0, upd_jal1;
  logic            upd_jalr0, upd_jalr1;
  logic            upd_branch0, upd_branch1;
  logic            upd_jump0, upd_jump1;
  logic [xlen-1:0] upd_pc0, upd_pc1;
  logic [xlen-1:0] upd_npc0, upd_npc1;
  logic [xlen-1:0] upd_addr0, upd_addr1;
  logic            taken;
  logic [xlen-1:0] taddr;
  logic [xlen-1:0] tpc;
  logic            pred_branch;
  logic [xlen-1:0] pred_baddr;
  logic [xlen-1:0] pred_pc;
  logic [xlen-1:0] pred_maddr;
  logic            pred_miss;
  logic [xlen-1:0] pred_raddr;
  logic            pred_rest;
  int              test_id;
  logic            done;
  int              error_count;
  logic            reported;
  integer          seed = 32'h07bbb13e;

  btac u_btac (.*);

  btac_checker u_checker (.*);

  always #10 clock = ~clock;

  // ============================================================
  // Stimulus helpers
  // ============================================================

  function automatic logic [xlen-1:0] random_pc();
    logic [31:0] r;
    r = $random(seed);
    return 32'h0000_1000 + {r[4:3], 7'b0} + {r[2:0], 1'b0};  // Eight indices, four tags each
  endfunction

  function automatic logic [xlen-1:0] even_word();
    logic [31:0] r;
    r = $random(seed);
    return {r[31:1], 1'b0};
  endfunction

  // Next cycle starts with no update, no strobe and a random lookup
  task automatic quiet_cycle();
    @(posedge clock);
    clear <= 1'b0;
    taken <= 1'b0;
    {upd_jal0, upd_jalr0, upd_branch0, upd_jump0} <= 4'b0;
    {upd_jal1, upd_jalr1, upd_branch1, upd_jump1} <= 4'b0;
    get_pc <= random_pc();
  endtask

  task automatic start_test(input int id);
    quiet_cycle();
    test_id <= id;
  endtask

  // Flags are {jump, branch, jalr, jal}
  task automatic load_slot(input logic slot, input logic [3:0] flags,
                           input logic [xlen-1:0] pc, input logic [xlen-1:0] addr);
    if (slot == 1'b0) begin
      {upd_jump0, upd_branch0, upd_jalr0, upd_jal0} <= flags;
      upd_pc0   <= pc;
      upd_npc0  <= pc + 4;
      upd_addr0 <= addr;
    end else begin
      {upd_jump1, upd_branch1, upd_jalr1, upd_jal1} <= flags;
      upd_pc1   <= pc;
      upd_npc1  <= pc + 4;
      upd_addr1 <= addr;
    end
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    logic [xlen-1:0] pc;
    logic [xlen-1:0] ta;
    logic [31:0]     r;

    clock  = 1'b0;
    reset  = 1'b0;
    clear  = 1'b0;
    get_pc = '0;
    {upd_jal0, upd_jalr0, upd_branch0, upd_jump0} = 4'b0;
    {upd_jal1, upd_jalr1, upd_branch1, upd_jump1} = 4'b0;
    {upd_pc0, upd_npc0, upd_addr0} = '0;
    {upd_pc1, upd_npc1, upd_addr1} = '0;
    taken   = 1'b0;
    taddr   = '0;
    tpc     = '0;
    test_id = 0;
    done    = 1'b0;

    repeat (3) @(posedge clock);
    reset <= 1'b1;

    start_test(1);
    repeat (n_empty) quiet_cycle();

    start_test(2);
    for (int i = 0; i < n_write; i++) begin
      pc = random_pc();
      quiet_cycle();
      load_slot(i[0], {3'b110, i[1]}, pc, even_word());
      quiet_cycle();
      get_pc <= pc;
      quiet_cycle();
      get_pc <= pc ^ 32'h80;  // Same index, other tag
    end

    start_test(3);
    repeat (n_merge) begin
      quiet_cycle();
      r = $random(seed);
      load_slot(1'b0, r[3:0], random_pc(), even_word());
      load_slot(1'b1, r[7:4], random_pc(), even_word());
      taken <= (r[9:8] == 2'b11);
      taddr <= even_word();
      tpc   <= random_pc();
    end

    start_test(4);
    for (int i = 0; i < n_taken; i++) begin
      ta = even_word();
      quiet_cycle();
      taken <= 1'b1;
      taddr <= ta;
      tpc   <= random_pc();
      r = $random(seed);
      if (r[0]) begin
        quiet_cycle();  // Record has to survive an idle cycle
      end
      quiet_cycle();
      load_slot(r[1], {r[2], 2'b10, r[3]}, random_pc(), r[4] ? ta : even_word());
      quiet_cycle();
      load_slot(r[1], 4'b0100, random_pc(), even_word());
    end

    start_test(5);
    repeat (n_clear) begin
      quiet_cycle();
      r = $random(seed);
      clear <= (r[1:0] == 2'b00);
      taken <= (r[3:2] == 2'b00);
      taddr <= even_word();
      tpc   <= random_pc();
      load_slot(r[4], r[8:5], random_pc(), even_word());
    end

    quiet_cycle();
    test_id <= 0;
    quiet_cycle();
    done <= 1'b1;
    wait (reported);
    if (error_count == 0 && u_btac.u_props.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // ============================================================
  // Watchdog
  // ============================================================

  initial begin
    #(watchdog_ns);
    $display("Timeout: the run did not end within %0d ns", watchdog_ns);
    $display("Something failed");
    $finish;
  end

endmodule

/* btac_checker.sv */
`timescale 1ns/1ps

module btac_checker import btac_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  int              test_id,
  input  logic            done,
  input  logic            clear,
  input  logic [xlen-1:0] get_pc,
  input  logic            upd_jal0, upd_jal1,
  input  logic            upd_jalr0, upd_jalr1,
  input  logic            upd_branch0, upd_branch1,
  input  logic            upd_jump0, upd_jump1,
  input  logic [xlen-1:0] upd_pc0, upd_pc1,
  input  logic [xlen-1:0] upd_npc0, upd_npc1,
  input  logic [xlen-1:0] upd_addr0, upd_addr1,
  input  logic            taken,
  input  logic [xlen-1:0] taddr,
  input  logic [xlen-1:0] tpc,
  input  logic            pred_branch,
  input  logic [xlen-1:0] pred_baddr,
  input  logic [xlen-1:0] pred_pc,
  input  logic [xlen-1:0] pred_maddr,
  input  logic            pred_miss,
  input  logic [xlen-1:0] pred_raddr,
  input  logic            pred_rest,
  output int              error_count,
  output logic            reported
);

  logic [3*xlen-1:0] model_table [0:btb_entries-1];  // Entry is {pc, target, next pc}
  logic              rec_valid;
  logic [xlen-1:0]   rec_addr;
  logic [xlen-1:0]   rec_pc;
  int                cur_test;
  int                test_checks;
  int                test_errors;
  int                total_checks;

  initial begin
    for (int i = 0; i < btb_entries; i++) begin
      model_table[i] = '0;
    end
    rec_valid    = 1'b0;
    rec_addr     = '0;
    rec_pc       = '0;
    cur_test     = 0;
    test_checks  = 0;
    test_errors  = 0;
    total_checks = 0;
    error_count  = 0;
    reported     = 1'b0;
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "empty_table";
      2:       return "write_then_hit";
      3:       return "dual_slot_merge";
      4:       return "taken_resolution";
      5:       return "clear_flush";
      default: return "idle";
    endcase
  endfunction

  task automatic compare(input string what, input logic [xlen-1:0] expected,
                         input logic [xlen-1:0] actual);
    test_checks++;
    total_checks++;
    if (actual !== expected) begin
      test_errors++;
      error_count++;
      $display("FAIL %s %s: expected %h, actual %h",
               test_name(cur_test), what, expected, actual);
    end
  endtask

  // ============================================================
  // Compare and model update
  // ============================================================

  always @(negedge clock) begin : watch
    logic              m_rest;
    logic              m_branch;
    logic              m_jump;
    logic [xlen-1:0]   m_pc;
    logic [xlen-1:0]   m_addr;
    logic [xlen-1:0]   m_npc;
    logic [3*xlen-1:0] entry;
    logic              eff_valid;
    logic [xlen-1:0]   eff_addr;
    logic [xlen-1:0]   eff_pc;
    logic              exp_hit;
    logic              exp_miss;

    if (test_id != cur_test) begin
      if (cur_test != 0) begin
        $display("Test %s done: %0d checks, %0d errors",
                 test_name(cur_test), test_checks, test_errors);
      end
      cur_test    = test_id;
      test_checks = 0;
      test_errors = 0;
    end

    m_rest    = upd_jal0 | upd_jal1 | upd_jalr0 | upd_jalr1;
    m_branch  = upd_branch0 | upd_branch1;
    m_jump    = upd_jump0 | upd_jump1;
    m_pc      = upd_jump0 ? upd_pc0 : upd_pc1;  // Slot 0 payload wins on its jump
    m_addr    = upd_jump0 ? upd_addr0 : upd_addr1;
    m_npc     = upd_jump0 ? upd_npc0 : upd_npc1;
    eff_valid = taken | rec_valid;  // A strobe counts in its own cycle
    eff_addr  = taken ? taddr : rec_addr;
    eff_pc    = taken ? tpc : rec_pc;

    if (!reset) begin
      rec_valid = 1'b0;
    end else if (clear) begin
      compare("pred_branch", '0, pred_branch);
      compare("pred_baddr", '0, pred_baddr);
      compare("pred_pc", '0, pred_pc);
      compare("pred_maddr", '0, pred_maddr);
      compare("pred_miss", '0, pred_miss);
      compare("pred_raddr", '0, pred_raddr);
      compare("pred_rest", '0, pred_rest);
      rec_valid = 1'b0;  // Record dropped and update lost
    end else begin
      entry   = model_table[get_pc[btb_index_width:1]];
      exp_hit = (entry != '0) && (entry[3*xlen-1:2*xlen] == get_pc);
      compare("pred_branch", exp_hit, pred_branch);
      if (exp_hit) begin
        compare("pred_baddr", entry[2*xlen-1:xlen], pred_baddr);
        compare("pred_pc", entry[xlen-1:0], pred_pc);
      end
      compare("pred_raddr", m_addr, pred_raddr);
      compare("pred_rest", m_rest, pred_rest);

      exp_miss = 1'b0;
      if (m_branch && m_jump) begin
        exp_miss = !eff_valid || (m_addr != eff_addr);
        compare("pred_maddr", m_addr, pred_maddr);
      end else if (m_branch && eff_valid) begin
        exp_miss = 1'b1;  // Predicted taken but it fell through
        compare("pred_maddr", eff_pc, pred_maddr);
      end
      compare("pred_miss", exp_miss, pred_miss);

      if (m_branch && m_jump) begin
        model_table[m_pc[btb_index_width:1]] = {m_pc, m_addr, m_npc};
      end
      if (m_branch) begin
        rec_valid = 1'b0;
      end else if (taken) begin
        rec_valid = 1'b1;
        rec_addr  = taddr;
        rec_pc    = tpc;
      end
    end

    if (done && !reported) begin
      $display("Totals: %0d checks, %0d errors", total_checks, error_count);
      reported = 1'b1;
    end
  end

endmodule

/* btac_props.sv */
`timescale 1ns/1ps

module btac_props import btac_pkg::*; (
  input logic            clock,
  input logic            reset,
  input logic            clear,
  input logic            upd_branch0,
  input logic            upd_branch1,
  input logic            btb_wen,
  input logic            pred_branch,
  input logic [xlen-1:0] pred_baddr,
  input logic [xlen-1:0] pred_pc,
  input logic [xlen-1:0] pred_maddr,
  input logic            pred_miss,
  input logic [xlen-1:0] pred_raddr,
  input logic            pred_rest
);

  int fail_count = 0;

  // ============================================================
  // Flush and resolution rules
  // ============================================================

  clear_zeroes_outputs: assert property (
    @(posedge clock) disable iff (!reset)
    clear |-> (!pred_branch && !pred_miss && !pred_rest && pred_baddr == '0
               && pred_pc == '0 && pred_maddr == '0 && pred_raddr == '0))
  else begin
    $error("Outputs are not all zero while clear is high");
    fail_count++;
  end

  miss_needs_branch: assert property (
    @(posedge clock) disable iff (!reset)
    pred_miss |-> (upd_branch0 || upd_branch1))
  else begin
    $error("Misprediction reported without a branch update");
    fail_count++;
  end

  // ============================================================
  // Table write
  // ============================================================

  no_write_on_clear: assert property (
    @(posedge clock) disable iff (!reset)
    clear |-> !btb_wen)
  else begin
    $error("Table written while clear is high");
    fail_count++;
  end

endmodule

bind btac btac_props u_props (.*);

/* btac.sv */
`timescale 1ns/1ps

module btac import btac_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            clear,
  input  logic [xlen-1:0] get_pc,
  input  logic            upd_jal0,
  input  logic            upd_jal1,
  input  logic            upd_jalr0,
  input  logic            upd_jalr1,
  input  logic            upd_branch0,
  input  logic            upd_branch1,
  input  logic            upd_jump0,
  input  logic            upd_jump1,
  input  logic [xlen-1:0] upd_pc0,
  input  logic [xlen-1:0] upd_pc1,
  input  logic [xlen-1:0] upd_npc0,
  input  logic [xlen-1:0] upd_npc1,
  input  logic [xlen-1:0] upd_addr0,
  input  logic [xlen-1:0] upd_addr1,
  input  logic            taken,
  input  logic [xlen-1:0] taddr,
  input  logic [xlen-1:0] tpc,
  output logic            pred_branch,
  output logic [xlen-1:0] pred_baddr,
  output logic [xlen-1:0] pred_pc,
  output logic [xlen-1:0] pred_maddr,
  output logic            pred_miss,
  output logic [xlen-1:0] pred_raddr,
  output logic            pred_rest
);

  logic [btb_index_width-1:0] btb_raddr;
  btb_entry_u                 btb_rdata;
  logic                       btb_wen;
  logic [btb_index_width-1:0] btb_waddr;
  btb_entry_u                 btb_wdata;

  logic            mrg_jal;
  logic            mrg_jalr;
  logic            mrg_branch;
  logic            mrg_jump;
  logic [xlen-1:0] mrg_addr;
  logic [xlen-1:0] mrg_npc;

  // ============================================================
  // Target table
  // ============================================================

  btb u_btb (
    .clock     (clock),
    .btb_raddr (btb_raddr),
    .btb_rdata (btb_rdata),
    .btb_wen   (btb_wen),
    .btb_waddr (btb_waddr),
    .btb_wdata (btb_wdata)
  );

  // ============================================================
  // Lookup and update merge
  // ============================================================

  btac_lookup u_lookup (
    .clear       (clear),
    .get_pc      (get_pc),
    .upd_jal0    (upd_jal0),
    .upd_jal1    (upd_jal1),
    .upd_jalr0   (upd_jalr0),
    .upd_jalr1   (upd_jalr1),
    .upd_branch0 (upd_branch0),
    .upd_branch1 (upd_branch1),
    .upd_jump0   (upd_jump0),
    .upd_jump1   (upd_jump1),
    .upd_pc0     (upd_pc0),
    .upd_pc1     (upd_pc1),
    .upd_npc0    (upd_npc0),
    .upd_npc1    (upd_npc1),
    .upd_addr0   (upd_addr0),
    .upd_addr1   (upd_addr1),
    .btb_rdata   (btb_rdata),
    .btb_raddr   (btb_raddr),
    .btb_wen     (btb_wen),
    .btb_waddr   (btb_waddr),
    .btb_wdata   (btb_wdata),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_pc     (pred_pc),
    .mrg_jal     (mrg_jal),
    .mrg_jalr    (mrg_jalr),
    .mrg_branch  (mrg_branch),
    .mrg_jump    (mrg_jump),
    .mrg_addr    (mrg_addr),
    .mrg_npc     (mrg_npc)
  );

  // ============================================================
  // Misprediction resolve
  // ============================================================

  btac_resolve u_resolve (
    .clock      (clock),
    .reset      (reset),
    .clear      (clear),
    .taken      (taken),
    .taddr      (taddr),
    .tpc        (tpc),
    .mrg_jal    (mrg_jal),
    .mrg_jalr   (mrg_jalr),
    .mrg_branch (mrg_branch),
    .mrg_jump   (mrg_jump),
    .mrg_addr   (mrg_addr),
    .mrg_npc    (mrg_npc),
    .pred_maddr (pred_maddr),
    .pred_miss  (pred_miss),
    .pred_raddr (pred_raddr),
    .pred_rest  (pred_rest)
  );

endmodule

/* btac_resolve.sv */
`timescale 1ns/1ps

module btac_resolve import btac_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            clear,
  input  logic            taken,
  input  logic [xlen-1:0] taddr,
  input  logic [xlen-1:0] tpc,
  input  logic            mrg_jal,
  input  logic            mrg_jalr,
  input  logic            mrg_branch,
  input  logic            mrg_jump,
  input  logic [xlen-1:0] mrg_addr,
  input  logic [xlen-1:0] mrg_npc,
  output logic [xlen-1:0] pred_maddr,
  output logic            pred_miss,
  output logic [xlen-1:0] pred_raddr,
  output logic            pred_rest
);

  logic            taken_q;
  logic [xlen-1:0] taddr_q;
  logic [xlen-1:0] tpc_q;

  logic            rec_valid;
  logic [xlen-1:0] rec_addr;
  logic [xlen-1:0] rec_pc;
  logic            rec_keep;

  // A strobe in this cycle replaces the held record at once
  always_comb begin
    if (taken) begin
      rec_valid = 1'b1;
      rec_addr  = taddr;
      rec_pc    = tpc;
    end else begin
      rec_valid = taken_q;
      rec_addr  = taddr_q;
      rec_pc    = tpc_q;
    end
  end

  // ============================================================
  // Resolution
  // ============================================================

  always_comb begin
    pred_maddr = '0;
    pred_miss  = 1'b0;
    pred_raddr = '0;
    pred_rest  = 1'b0;
    rec_keep   = rec_valid;

    if (!clear) begin
      pred_raddr = mrg_addr;
      pred_rest  = mrg_jal | mrg_jalr;  // Return stack acts on any link jump

      if (mrg_branch) begin
        if (!rec_valid) begin
          if (mrg_jump) begin
            pred_maddr = mrg_addr;  // Fetch went straight on past a taken jump
            pred_miss  = 1'b1;
          end else begin
            pred_maddr = mrg_npc;
          end
        end else begin
          rec_keep = 1'b0;  // Each resolved branch uses up the record
          if (mrg_jump) begin
            pred_maddr = mrg_addr;
            pred_miss  = (mrg_addr != rec_addr);
          end else begin
            pred_maddr = rec_pc;  // Predicted taken but fell through
            pred_miss  = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      taken_q <= 1'b0;
      taddr_q <= '0;
      tpc_q   <= '0;
    end else begin
      taken_q <= rec_keep;
      taddr_q <= rec_addr;
      tpc_q   <= rec_pc;
    end
  end

endmodule

/* btac_lookup.sv */
`timescale 1ns/1ps

module btac_lookup import btac_pkg::*; (
  input  logic                       clear,
  input  logic [xlen-1:0]            get_pc,
  input  logic                       upd_jal0,
  input  logic                       upd_jal1,
  input  logic                       upd_jalr0,
  input  logic                       upd_jalr1,
  input  logic                       upd_branch0,
  input  logic                       upd_branch1,
  input  logic                       upd_jump0,
  input  logic                       upd_jump1,
  input  logic [xlen-1:0]            upd_pc0,
  input  logic [xlen-1:0]            upd_pc1,
  input  logic [xlen-1:0]            upd_npc0,
  input  logic [xlen-1:0]            upd_npc1,
  input  logic [xlen-1:0]            upd_addr0,
  input  logic [xlen-1:0]            upd_addr1,
  input  btb_entry_u                 btb_rdata,
  output logic [btb_index_width-1:0] btb_raddr,
  output logic                       btb_wen,
  output logic [btb_index_width-1:0] btb_waddr,
  output btb_entry_u                 btb_wdata,
  output logic                       pred_branch,
  output logic [xlen-1:0]            pred_baddr,
  output logic [xlen-1:0]            pred_pc,
  output logic                       mrg_jal,
  output logic                       mrg_jalr,
  output logic                       mrg_branch,
  output logic                       mrg_jump,
  output logic [xlen-1:0]            mrg_addr,
  output logic [xlen-1:0]            mrg_npc
);

  logic [xlen-1:0] mrg_pc;
  logic            entry_valid;
  logic            tag_match;

  // ============================================================
  // Slot merge
  // ============================================================

  always_comb begin
    mrg_jal    = upd_jal0 | upd_jal1;
    mrg_jalr   = upd_jalr0 | upd_jalr1;
    mrg_branch = upd_branch0 | upd_branch1;
    mrg_jump   = upd_jump0 | upd_jump1;

    // A jump in slot 0 is older in program order, so its payload wins
    if (upd_jump0) begin
      mrg_pc   = upd_pc0;
      mrg_npc  = upd_npc0;
      mrg_addr = upd_addr0;
    end else begin
      mrg_pc   = upd_pc1;
      mrg_npc  = upd_npc1;
      mrg_addr = upd_addr1;
    end
  end

  // ============================================================
  // Table write
  // ============================================================

  always_comb begin
    btb_wen   = mrg_branch & mrg_jump & ~clear;  // Only resolved jumps allocate
    btb_waddr = mrg_pc[btb_index_width:1];

    btb_wdata.fields.tag_pc  = mrg_pc;
    btb_wdata.fields.target  = mrg_addr;
    btb_wdata.fields.next_pc = mrg_npc;
  end

  // ============================================================
  // Prediction
  // ============================================================

  assign btb_raddr = get_pc[btb_index_width:1];

  assign entry_valid = |btb_rdata.raw;  // Zero word means never written
  assign tag_match   = (btb_rdata.fields.tag_pc == get_pc);

  always_comb begin
    if (clear) begin
      pred_branch = 1'b0;
      pred_baddr  = '0;
      pred_pc     = '0;
    end else begin
      pred_branch = entry_valid & tag_match;  // Full pc tag so aliases never hit
      pred_baddr  = btb_rdata.fields.target;
      pred_pc     = btb_rdata.fields.next_pc;
    end
  end

endmodule

/* btb.sv */
`timescale 1ns/1ps

module btb import btac_pkg::*; (
  input  logic                       clock,
  input  logic [btb_index_width-1:0] btb_raddr,
  output btb_entry_u                 btb_rdata,
  input  logic                       btb_wen,
  input  logic [btb_index_width-1:0] btb_waddr,
  input  btb_entry_u                 btb_wdata
);

  // ============================================================
  // Storage
  // ============================================================

  logic [btb_word_width-1:0] table_mem [0:btb_entries-1] = '{default: '0};  // Powers up empty

  // ============================================================
  // Ports
  // ============================================================

  assign btb_rdata.raw = table_mem[btb_raddr];  // Read in the same cycle as the lookup

  always_ff @(posedge clock) begin
    if (btb_wen) begin
      table_mem[btb_waddr] <= btb_wdata.raw;  // Visible to lookups from the next cycle on
    end
  end

endmodule

/* btac_pkg.sv */
package btac_pkg;

  // ============================================================
  // Table geometry
  // ============================================================

  localparam int xlen = 32;

  localparam int btb_entries = 64;  // One word per halfword slot in a 128-byte window

  localparam int btb_index_width = $clog2(btb_entries);  // Indexed by pc bits 6 down to 1

  localparam int btb_word_width = 3 * xlen;

  // ============================================================
  // Table entry
  // ============================================================

  // Prediction and write logic see three fields; the table itself
  // stores and tests one raw word
  typedef union packed {
    struct packed {
      logic [xlen-1:0] tag_pc;   // Pc of the resolved jump
      logic [xlen-1:0] target;   // Where the jump went
      logic [xlen-1:0] next_pc;  // Fall-through pc of the jump
    } fields;
    logic [btb_word_width-1:0] raw;  // All zero marks an empty slot
  } btb_entry_u;

endpackage
